//--- lc3Pkg.sv
package lc3Pkg;

    localparam int c_WordW    = 16;
    localparam int c_RegCount = 8;

    typedef logic [c_WordW-1:0]            word_t;
    typedef logic [$clog2(c_RegCount)-1:0] regIdx_t;

    localparam word_t c_ResetPc = 16'h3000;  // First fetch address

    // LC-3 encodings, the rest are skipped by the core
    typedef enum logic [3:0] {
        OpBr  = 4'b0000,
        OpAdd = 4'b0001,
        OpLd  = 4'b0010,
        OpSt  = 4'b0011,
        OpAnd = 4'b0101,
        OpLdr = 4'b0110,
        OpStr = 4'b0111,
        OpNot = 4'b1001,
        OpLea = 4'b1110
    } opcode_t;

    typedef enum logic [1:0] {
        AluAdd,
        AluAnd,
        AluNot,
        AluPass  // Second source register straight through
    } aluOp_t;

    typedef enum logic [2:0] {
        BusNone,
        BusPc,
        BusAlu,
        BusAddr,
        BusMdr
    } busSrc_t;

    typedef enum logic {
        Addr1Pc,
        Addr1Base
    } addr1Sel_t;

    typedef enum logic [1:0] {
        Addr2Zero,
        Addr2Off6,
        Addr2Off9
    } addr2Sel_t;

    typedef enum logic [3:0] {
        StFetchMar, StFetchRead, StFetchIr, StDecode,
        StAlu, StLea, StAddrMar, StLoadRead,
        StLoadDr, StStoreMdr, StStoreWrite, StBranch
    } ctrlState_t;

endpackage

//--- lc3CtrlIf.sv
`timescale 1ns/1ps

interface lc3CtrlIf;
    import lc3Pkg::*;

    busSrc_t   busSrc;      // Which result drives the bus
    aluOp_t    aluOp;
    addr1Sel_t addr1Sel;
    addr2Sel_t addr2Sel;
    logic      sr2FromDr;   // Store source from IR[11:9]
    logic      pcFromAddr;  // PC from adder, else PC + 1
    logic      mdrFromMem;
    logic      ldPc;
    logic      ldMar;
    logic      ldMdr;
    logic      ldIr;
    logic      ldReg;
    logic      ldCc;

    // Status back to the sequencer
    opcode_t   opcode;
    logic      ben;

    modport ctrl (
        output busSrc, aluOp, addr1Sel, addr2Sel,
        output sr2FromDr, pcFromAddr, mdrFromMem,
        output ldPc, ldMar, ldMdr, ldIr, ldReg, ldCc,
        input  opcode, ben
    );

    modport dp (
        input  busSrc, aluOp, addr1Sel, addr2Sel,
        input  sr2FromDr, pcFromAddr, mdrFromMem,
        input  ldPc, ldMar, ldMdr, ldIr, ldReg, ldCc,
        output opcode, ben
    );

endinterface

//--- lc3RegFile.sv
`timescale 1ns/1ps

module lc3RegFile (
    input  logic            i_Clk,
    input  logic            i_rstN,
    input  lc3Pkg::regIdx_t i_sr1,
    input  lc3Pkg::regIdx_t i_sr2,
    input  lc3Pkg::regIdx_t i_dr,
    input  logic            i_ld,
    input  lc3Pkg::word_t   i_data,
    output lc3Pkg::word_t   o_sr1Data,
    output lc3Pkg::word_t   o_sr2Data
);
    import lc3Pkg::*;

    word_t regs [c_RegCount];

    // R0..R7 all start at zero
    always_ff @(posedge i_Clk)
    begin
        if (!i_rstN)
        begin
            for (int i = 0; i < c_RegCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_ld)
        begin
            regs[i_dr] <= i_data;
        end
    end

    // Asynchronous reads, a write shows up the next cycle
    assign o_sr1Data = regs[i_sr1];
    assign o_sr2Data = regs[i_sr2];

endmodule

//--- lc3Alu.sv
`timescale 1ns/1ps

module lc3Alu (
    input  lc3Pkg::aluOp_t i_op,
    input  lc3Pkg::word_t  i_a,
    input  lc3Pkg::word_t  i_b,
    input  logic [4:0]     i_imm5,
    input  logic           i_useImm,  // IR bit 5
    output lc3Pkg::word_t  o_result
);
    import lc3Pkg::*;

    word_t immExt;
    word_t opB;

    assign immExt = {{(c_WordW-5){i_imm5[4]}}, i_imm5};
    assign opB    = i_useImm ? immExt : i_b;

    always_comb
    begin
        case (i_op)
            AluAdd:  o_result = i_a + opB;
            AluAnd:  o_result = i_a & opB;
            AluNot:  o_result = ~i_a;
            AluPass: o_result = i_b;  // Raw register, never the immediate
            default: o_result = i_b;
        endcase
    end

endmodule

//--- lc3AddrGen.sv
`timescale 1ns/1ps

module lc3AddrGen (
    input  lc3Pkg::word_t     i_ir,
    input  lc3Pkg::word_t     i_pc,
    input  lc3Pkg::word_t     i_base,  // BaseR from the SR1 port
    input  lc3Pkg::addr1Sel_t i_addr1Sel,
    input  lc3Pkg::addr2Sel_t i_addr2Sel,
    output lc3Pkg::word_t     o_addr
);
    import lc3Pkg::*;

    word_t off6;
    word_t off9;
    word_t addr1;
    word_t addr2;

    assign off6 = {{(c_WordW-6){i_ir[5]}}, i_ir[5:0]};
    assign off9 = {{(c_WordW-9){i_ir[8]}}, i_ir[8:0]};

    assign addr1 = (i_addr1Sel == Addr1Base) ? i_base : i_pc;

    always_comb
    begin
        case (i_addr2Sel)
            Addr2Off6: addr2 = off6;  // LDR, STR
            Addr2Off9: addr2 = off9;  // LEA, LD, ST, BR
            default:   addr2 = '0;
        endcase
    end

    // One adder for every address form
    assign o_addr = addr1 + addr2;

endmodule

//--- lc3Datapath.sv
`timescale 1ns/1ps

module lc3Datapath (
    input  logic          i_Clk,
    input  logic          i_rstN,
    lc3CtrlIf.dp          ctrlIf,
    input  lc3Pkg::word_t i_wbDatR,
    output lc3Pkg::word_t o_wbAdr,
    output lc3Pkg::word_t o_wbDatW
);
    import lc3Pkg::*;

    word_t   pc;
    word_t   ir;
    word_t   mar;
    word_t   mdr;
    logic    flagN, flagZ, flagP;
    logic    benQ;
    word_t   bus;
    word_t   sr1Data;
    word_t   sr2Data;
    word_t   aluResult;
    word_t   addr;
    regIdx_t sr2Idx;

    assign sr2Idx = ctrlIf.sr2FromDr ? ir[11:9] : ir[2:0];

    lc3RegFile regFile_i (
        .i_Clk     (i_Clk),
        .i_rstN    (i_rstN),
        .i_sr1     (ir[8:6]),
        .i_sr2     (sr2Idx),
        .i_dr      (ir[11:9]),
        .i_ld      (ctrlIf.ldReg),
        .i_data    (bus),
        .o_sr1Data (sr1Data),
        .o_sr2Data (sr2Data)
    );

    lc3Alu alu_i (
        .i_op     (ctrlIf.aluOp),
        .i_a      (sr1Data),
        .i_b      (sr2Data),
        .i_imm5   (ir[4:0]),
        .i_useImm (ir[5]),
        .o_result (aluResult)
    );

    lc3AddrGen addrGen_i (
        .i_ir       (ir),
        .i_pc       (pc),
        .i_base     (sr1Data),
        .i_addr1Sel (ctrlIf.addr1Sel),
        .i_addr2Sel (ctrlIf.addr2Sel),
        .o_addr     (addr)
    );

    always_comb
    begin
        case (ctrlIf.busSrc)
            BusPc:   bus = pc;
            BusAlu:  bus = aluResult;
            BusAddr: bus = addr;
            BusMdr:  bus = mdr;
            default: bus = '0;  // Bus idle
        endcase
    end

    always_ff @(posedge i_Clk)
    begin
        if (!i_rstN)
        begin
            pc    <= c_ResetPc;
            ir    <= '0;
            flagN <= 1'b0;
            flagZ <= 1'b1;
            flagP <= 1'b0;
            benQ  <= 1'b0;
        end
        else
        begin
            if (ctrlIf.ldPc)
                pc <= ctrlIf.pcFromAddr ? addr : pc + 1'b1;
            if (ctrlIf.ldIr)
                ir <= bus;
            if (ctrlIf.ldCc)
            begin
                flagN <= bus[c_WordW-1];
                flagZ <= (bus == '0);
                flagP <= !bus[c_WordW-1] && (bus != '0);
            end
            // Captured at decode, IR and flags hold until the branch step
            benQ <= (ir[11] & flagN) | (ir[10] & flagZ) | (ir[9] & flagP);
        end
    end

    // Bus-side registers
    always_ff @(posedge i_Clk)
    begin
        if (ctrlIf.ldMar)
            mar <= bus;
        if (ctrlIf.ldMdr)
            mdr <= ctrlIf.mdrFromMem ? i_wbDatR : bus;
    end

    assign ctrlIf.opcode = opcode_t'(ir[15:12]);
    assign ctrlIf.ben    = benQ;
    assign o_wbAdr       = mar;
    assign o_wbDatW      = mdr;

    // Flags only ever come from a driven bus
    aCcNeedsBus: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        ctrlIf.ldCc |-> ctrlIf.busSrc != BusNone);

endmodule

//--- lc3Control.sv
`timescale 1ns/1ps

module lc3Control (
    input  logic i_Clk,
    input  logic i_rstN,
    lc3CtrlIf.ctrl ctrlIf,
    input  logic i_wbAck,
    output logic o_wbCyc,
    output logic o_wbStb,
    output logic o_wbWe
);
    import lc3Pkg::*;

    ctrlState_t state;
    ctrlState_t nextState;
    logic       isRegBased;  // LDR or STR

    assign isRegBased = (ctrlIf.opcode == OpLdr) || (ctrlIf.opcode == OpStr);

    // Reset parks in the branch step with ben clear, a not-taken branch
    always_ff @(posedge i_Clk)
    begin
        if (!i_rstN)
            state <= StBranch;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = state;
        case (state)
            StFetchMar:  nextState = StFetchRead;
            StFetchRead: nextState = i_wbAck ? StFetchIr : StFetchRead;
            StFetchIr:   nextState = StDecode;
            StDecode:
            begin
                case (ctrlIf.opcode)
                    OpAdd, OpAnd, OpNot: nextState = StAlu;
                    OpLea:               nextState = StLea;
                    OpLd, OpLdr:         nextState = StAddrMar;
                    OpSt, OpStr:         nextState = StAddrMar;
                    OpBr:                nextState = StBranch;
                    default:             nextState = StFetchMar;  // Unsupported, skip
                endcase
            end
            StAddrMar:
            begin
                if (ctrlIf.opcode == OpLd || ctrlIf.opcode == OpLdr)
                    nextState = StLoadRead;
                else
                    nextState = StStoreMdr;
            end
            StLoadRead:   nextState = i_wbAck ? StLoadDr : StLoadRead;
            StStoreMdr:   nextState = StStoreWrite;
            StStoreWrite: nextState = i_wbAck ? StFetchMar : StStoreWrite;
            default:      nextState = StFetchMar;  // ALU, LEA, load DR, branch
        endcase
    end

    always_comb
    begin
        ctrlIf.busSrc     = BusNone;
        ctrlIf.aluOp      = AluAdd;
        ctrlIf.addr1Sel   = Addr1Pc;
        ctrlIf.addr2Sel   = Addr2Zero;
        ctrlIf.sr2FromDr  = 1'b0;
        ctrlIf.pcFromAddr = 1'b0;
        ctrlIf.mdrFromMem = 1'b0;
        ctrlIf.ldPc       = 1'b0;
        ctrlIf.ldMar      = 1'b0;
        ctrlIf.ldMdr      = 1'b0;
        ctrlIf.ldIr       = 1'b0;
        ctrlIf.ldReg      = 1'b0;
        ctrlIf.ldCc       = 1'b0;
        case (state)
            StFetchMar:
            begin
                ctrlIf.busSrc = BusPc;  // MAR <- PC, PC <- PC + 1
                ctrlIf.ldMar  = 1'b1;
                ctrlIf.ldPc   = 1'b1;
            end
            StFetchRead, StLoadRead:
            begin
                ctrlIf.mdrFromMem = 1'b1;
                ctrlIf.ldMdr      = i_wbAck;
            end
            StFetchIr:
            begin
                ctrlIf.busSrc = BusMdr;
                ctrlIf.ldIr   = 1'b1;
            end
            StAlu:
            begin
                ctrlIf.busSrc = BusAlu;
                case (ctrlIf.opcode)
                    OpAnd:   ctrlIf.aluOp = AluAnd;
                    OpNot:   ctrlIf.aluOp = AluNot;
                    default: ctrlIf.aluOp = AluAdd;
                endcase
                ctrlIf.ldReg = 1'b1;
                ctrlIf.ldCc  = 1'b1;
            end
            StLea:
            begin
                ctrlIf.busSrc   = BusAddr;
                ctrlIf.addr2Sel = Addr2Off9;
                ctrlIf.ldReg    = 1'b1;
                ctrlIf.ldCc     = 1'b1;
            end
            StAddrMar:
            begin
                ctrlIf.busSrc   = BusAddr;
                ctrlIf.addr1Sel = isRegBased ? Addr1Base : Addr1Pc;
                ctrlIf.addr2Sel = isRegBased ? Addr2Off6 : Addr2Off9;
                ctrlIf.ldMar    = 1'b1;
            end
            StLoadDr:
            begin
                ctrlIf.busSrc = BusMdr;
                ctrlIf.ldReg  = 1'b1;
                ctrlIf.ldCc   = 1'b1;
            end
            StStoreMdr:
            begin
                ctrlIf.busSrc    = BusAlu;  // MDR <- SR
                ctrlIf.aluOp     = AluPass;
                ctrlIf.sr2FromDr = 1'b1;
                ctrlIf.ldMdr     = 1'b1;
            end
            StBranch:
            begin
                ctrlIf.addr2Sel   = Addr2Off9;
                ctrlIf.pcFromAddr = 1'b1;
                ctrlIf.ldPc       = ctrlIf.ben;
            end
            default:
            begin
            end
        endcase
    end

    // Wishbone classic, one access per memory state
    assign o_wbCyc = (state == StFetchRead) || (state == StLoadRead) || (state == StStoreWrite);
    assign o_wbStb = o_wbCyc;
    assign o_wbWe  = (state == StStoreWrite);

    aStbCyc: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        o_wbStb |-> o_wbCyc);

    // MAR and write data held in the datapath for the whole access
    aHold: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        (o_wbStb && !i_wbAck) |=> (o_wbStb && $stable(o_wbWe)));
    aNoReload: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        o_wbStb |-> (!ctrlIf.ldMar && !(o_wbWe && ctrlIf.ldMdr)));

    aLegalState: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        state inside {StFetchMar, StFetchRead, StFetchIr, StDecode, StAlu, StLea,
                      StAddrMar, StLoadRead, StLoadDr, StStoreMdr, StStoreWrite,
                      StBranch});

endmodule

//--- lc3Core.sv
`timescale 1ns/1ps

module lc3Core (
    input  logic          i_Clk,
    input  logic          i_rstN,
    output logic          o_wbCyc,
    output logic          o_wbStb,
    output logic          o_wbWe,
    output lc3Pkg::word_t o_wbAdr,
    output lc3Pkg::word_t o_wbDatW,
    input  lc3Pkg::word_t i_wbDatR,
    input  logic          i_wbAck
);

    lc3CtrlIf ctrlIf ();

    // Sequencer and Wishbone handshake
    lc3Control control_i (
        .i_Clk   (i_Clk),
        .i_rstN  (i_rstN),
        .ctrlIf  (ctrlIf.ctrl),
        .i_wbAck (i_wbAck),
        .o_wbCyc (o_wbCyc),
        .o_wbStb (o_wbStb),
        .o_wbWe  (o_wbWe)
    );

    // Registers, ALU and address adder
    lc3Datapath datapath_i (
        .i_Clk    (i_Clk),
        .i_rstN   (i_rstN),
        .ctrlIf   (ctrlIf.dp),
        .i_wbDatR (i_wbDatR),
        .o_wbAdr  (o_wbAdr),
        .o_wbDatW (o_wbDatW)
    );

endmodule

//--- lc3MemModel.sv
`timescale 1ns/1ps

module lc3MemModel #(
    parameter logic [31:0] seedInit = 32'h0
) (
    input  logic          i_Clk,
    input  logic          i_rstN,
    input  logic          i_cyc,
    input  logic          i_stb,
    input  logic          i_we,
    input  lc3Pkg::word_t i_adr,
    input  lc3Pkg::word_t i_datW,
    output lc3Pkg::word_t o_datR,
    output logic          o_ack
);
    import lc3Pkg::*;

    word_t  mem [65536];  // Whole 16-bit space, loaded by the testbench
    integer seed;
    integer draw;
    int     waitLeft;
    logic   busy;         // Wait count drawn for the current strobe

    initial
    begin
        seed     = seedInit;
        busy     = 1'b0;
        waitLeft = 0;
        o_ack    = 1'b0;
        o_datR   = '0;
    end

    // Registered ack, outputs change 1 ns after the edge
    always @(posedge i_Clk)
    begin
        if (!i_rstN)
        begin
            busy = 1'b0;
            o_ack <= #1 1'b0;
        end
        else if (o_ack)
        begin
            busy = 1'b0;  // Master drops the strobe at this edge
            o_ack <= #1 1'b0;
        end
        else if (i_cyc && i_stb)
        begin
            if (!busy)
            begin
                draw     = $random(seed);
                waitLeft = draw & 3;  // 0 to 3 wait cycles
                busy     = 1'b1;
            end
            if (waitLeft == 0)
            begin
                if (i_we)
                    mem[i_adr] = i_datW;
                else
                    o_datR <= #1 mem[i_adr];
                o_ack <= #1 1'b1;
            end
            else
                waitLeft = waitLeft - 1;
        end
    end

endmodule

//--- lc3Core_tb.sv
`timescale 1ns/1ps

module lc3Core_tb;
    import lc3Pkg::*;

    localparam logic [31:0] c_Seed       = 32'hab80_dcdb;
    localparam word_t       c_HaltAddr   = 16'h301E;  // BRnzp to itself
    localparam int          c_RunTimeout = 2000;      // Clock cycles

    typedef struct packed {
        logic  fetch;
        logic  we;
        word_t adr;
        word_t dat;
    } access_t;

    logic  clk;
    logic  rstN;
    logic  wbCyc;
    logic  wbStb;
    logic  wbWe;
    logic  wbAck;
    word_t wbAdr;
    word_t wbDatW;
    word_t wbDatR;

    // ISA-level model state
    word_t   refMem [65536];
    word_t   modelReg [c_RegCount];
    word_t   modelPc;
    logic    modelN;
    logic    modelZ;
    logic    modelP;
    access_t expQ [$];  // Accesses the model predicts, in order
    int      haltFetches;

    lc3Core lc3Core_i (
        .i_Clk    (clk),
        .i_rstN   (rstN),
        .o_wbCyc  (wbCyc),
        .o_wbStb  (wbStb),
        .o_wbWe   (wbWe),
        .o_wbAdr  (wbAdr),
        .o_wbDatW (wbDatW),
        .i_wbDatR (wbDatR),
        .i_wbAck  (wbAck)
    );

    lc3MemModel #(
        .seedInit (c_Seed)
    ) memModel_i (
        .i_Clk  (clk),
        .i_rstN (rstN),
        .i_cyc  (wbCyc),
        .i_stb  (wbStb),
        .i_we   (wbWe),
        .i_adr  (wbAdr),
        .i_datW (wbDatW),
        .o_datR (wbDatR),
        .o_ack  (wbAck)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t want);
        assert (got === want)
        else
            failRun($sformatf("mismatch %s got %h expected %h", name, got, want));
    endtask

    aStbNeedsCyc: assert property (@(posedge clk) disable iff (!rstN) wbStb |-> wbCyc)
        else failRun("strobe high without cycle");

    // Request held until the slave answers
    aHoldUntilAck: assert property (@(posedge clk) disable iff (!rstN)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatW)))
        else failRun("bus request dropped or changed before acknowledge");

    function automatic word_t sext(input word_t v, input int bits);
        word_t m;
        m    = 16'hFFFF << bits;
        sext = v[bits-1] ? (v | m) : (v & ~m);
    endfunction

    function automatic word_t encReg(input opcode_t op, input int dr, input int sr1,
                                     input int sr2);
        encReg = {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
    endfunction

    function automatic word_t encImm(input opcode_t op, input int dr, input int sr1,
                                     input int imm);
        encImm = {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
    endfunction

    function automatic word_t encOff6(input opcode_t op, input int r, input int base,
                                      input int off);
        encOff6 = {op, r[2:0], base[2:0], off[5:0]};
    endfunction

    // For BR the register field holds n, z, p
    function automatic word_t encOff9(input opcode_t op, input int r, input int off);
        encOff9 = {op, r[2:0], off[8:0]};
    endfunction

    task automatic place(input word_t addr, input word_t data);
        memModel_i.mem[addr] = data;
        refMem[addr]         = data;
    endtask

    task automatic queueAccess(input logic fetch, input logic we, input word_t adr,
                               input word_t dat);
        access_t a;
        a.fetch = fetch;
        a.we    = we;
        a.adr   = adr;
        a.dat   = dat;
        expQ.push_back(a);
    endtask

    task automatic initModel();
        for (int r = 0; r < c_RegCount; r++)
            modelReg[r] = '0;
        modelPc = c_ResetPc;
        modelN  = 1'b0;
        modelZ  = 1'b0;
        modelP  = 1'b0;
        expQ.delete();
        queueAccess(1'b1, 1'b0, c_ResetPc, '0);  // First access after reset
    endtask

    // Executes one instruction and queues its accesses and the next fetch
    task automatic stepModel(input word_t instr);
        word_t opB;
        word_t res;
        word_t addr;
        logic  wrReg;
        wrReg   = 1'b0;
        res     = '0;
        modelPc = modelPc + 1'b1;
        opB     = instr[5] ? sext(instr, 5) : modelReg[instr[2:0]];
        case (instr[15:12])
            OpAdd:
            begin
                res   = modelReg[instr[8:6]] + opB;
                wrReg = 1'b1;
            end
            OpAnd:
            begin
                res   = modelReg[instr[8:6]] & opB;
                wrReg = 1'b1;
            end
            OpNot:
            begin
                res   = ~modelReg[instr[8:6]];
                wrReg = 1'b1;
            end
            OpLea:
            begin
                res   = modelPc + sext(instr, 9);
                wrReg = 1'b1;
            end
            OpLd, OpLdr:
            begin
                if (instr[15:12] == OpLd)
                    addr = modelPc + sext(instr, 9);
                else
                    addr = modelReg[instr[8:6]] + sext(instr, 6);
                queueAccess(1'b0, 1'b0, addr, '0);
                res   = refMem[addr];
                wrReg = 1'b1;
            end
            OpSt, OpStr:
            begin
                if (instr[15:12] == OpSt)
                    addr = modelPc + sext(instr, 9);
                else
                    addr = modelReg[instr[8:6]] + sext(instr, 6);
                queueAccess(1'b0, 1'b1, addr, modelReg[instr[11:9]]);
                refMem[addr] = modelReg[instr[11:9]];
            end
            OpBr:
            begin
                if ((instr[11] && modelN) || (instr[10] && modelZ) || (instr[9] && modelP))
                    modelPc = modelPc + sext(instr, 9);
            end
            default:
            begin
                // Skipped opcode, nothing changes
            end
        endcase
        if (wrReg)
        begin
            modelReg[instr[11:9]] = res;
            modelN = res[15];
            modelZ = (res == '0);
            modelP = !res[15] && (res != '0);
        end
        queueAccess(1'b1, 1'b0, modelPc, '0);
    endtask

    task automatic checkAccess();
        access_t want;
        if (expQ.size() == 0)
            failRun("bus access seen while the model expects none");
        else
        begin
            want = expQ.pop_front();
            checkWord("o_wbAdr", wbAdr, want.adr);
            checkWord("o_wbWe", {15'h0, wbWe}, {15'h0, want.we});
            if (want.we)
                checkWord("o_wbDatW", wbDatW, want.dat);
            if (want.fetch)
            begin
                if (want.adr == c_HaltAddr)
                    haltFetches++;
                stepModel(refMem[want.adr]);
            end
        end
    endtask

    task automatic loadProgram();
        for (int a = 0; a < 65536; a++)
            place(word_t'(a), {a[7:0], a[15:8]} ^ 16'h96c3);
        place(16'h3000, encOff9(OpLea, 1, 'h3F));     // R1 = 0x3040
        place(16'h3001, encOff9(OpLd, 2, 'h3E));
        place(16'h3002, encOff6(OpLdr, 3, 1, 1));
        place(16'h3003, encReg(OpAdd, 4, 2, 3));
        place(16'h3004, encImm(OpAdd, 5, 2, -3));
        place(16'h3005, encReg(OpAnd, 6, 2, 3));
        place(16'h3006, encImm(OpAnd, 7, 3, 'hF));    // Zero result
        place(16'h3007, encImm(OpNot, 0, 2, -1));     // NOT has bits 5:0 all set
        place(16'h3008, encOff6(OpStr, 4, 1, 'h10));
        place(16'h3009, encOff6(OpStr, 5, 1, 'h11));
        place(16'h300A, encOff6(OpStr, 6, 1, 'h12));
        place(16'h300B, encOff6(OpStr, 7, 1, 'h13));
        place(16'h300C, encOff9(OpSt, 0, 'h47));      // To 0x3054
        place(16'h300D, encOff9(OpSt, 2, 'h47));
        place(16'h300E, encOff9(OpSt, 3, 'h47));
        place(16'h300F, 16'hD123);                    // Reserved opcode
        place(16'h3010, 16'h8000);                    // RTI, not in this core
        place(16'h3011, encOff6(OpStr, 1, 1, 'h17));
        place(16'h3012, encOff9(OpBr, 2, 1));         // BRz not taken
        place(16'h3013, encOff9(OpBr, 4, 1));         // BRn taken
        place(16'h3014, encImm(OpAdd, 0, 0, 1));
        place(16'h3015, encImm(OpAnd, 2, 2, 0));
        place(16'h3016, encOff9(OpBr, 1, -3));
        place(16'h3017, encOff9(OpBr, 2, 1));
        place(16'h3018, encImm(OpNot, 0, 0, -1));
        place(16'h3019, encImm(OpAdd, 2, 2, 3));
        place(16'h301A, encImm(OpAdd, 2, 2, -1));     // Countdown loop
        place(16'h301B, encOff9(OpBr, 1, -2));
        place(16'h301C, encOff6(OpStr, 2, 1, 'h18));
        place(16'h301D, encOff9(OpSt, 0, 'h3B));      // To 0x3059
        place(c_HaltAddr, encOff9(OpBr, 7, -1));
        place(16'h3040, 16'h1234);
        place(16'h3041, 16'hFFF0);
    endtask

    // Outputs are settled half a cycle after the edge
    always @(negedge clk)
    begin
        if (!rstN)
        begin
            assert (!wbCyc && !wbStb)
            else
                failRun("bus cycle active while reset is asserted");
        end
        else if (wbStb && wbAck)
            checkAccess();
    end

    initial
    begin
        int waitCycles;
        rstN        = 1'b0;
        haltFetches = 0;
        waitCycles  = 0;
        loadProgram();
        initModel();
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;
        while (haltFetches < 2 && waitCycles < c_RunTimeout)
        begin
            @(posedge clk);
            waitCycles++;
        end
        if (haltFetches >= 2)
        begin
            $display("No errors");
            $finish;
        end
        else
            failRun("timeout waiting for the program to reach its halt loop");
    end

endmodule

//--- lc3Core.f
lc3Pkg.sv
lc3CtrlIf.sv
lc3RegFile.sv
lc3Alu.sv
lc3AddrGen.sv
lc3Datapath.sv
lc3Control.sv
lc3Core.sv
lc3MemModel.sv
lc3Core_tb.sv
